// ==== Makefile ====
# Verilator build and run of the decompressor testbench
VERILATOR ?= verilator
TOP       ?= tb_decompressor
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== common/decomp_defines.svh ====
`ifndef DECOMP_DEFINES_SVH
`define DECOMP_DEFINES_SVH

// memory side, one compress group arrives per memory word
`define MEM_BANDWIDTH 8                   // bytes returned per memory word
`define GROUP_BITS (`MEM_BANDWIDTH * 8)   // a compress group fills exactly one word

// layout of a compress unit, the zero run sits in the low bits
`define UNITS_PER_GROUP 5                 // units packed into bits 0 to 59
`define ZERO_BITS 4                       // zero run of up to 15
`define VAL_BITS 8                        // one feature map byte
`define UNIT_BITS (`ZERO_BITS + `VAL_BITS)

// end index value telling that every unit of the group is valid
`define END_ALL_VALID 7

// packets written into the global buffer
`define PACKET_BYTES 8

// one slot per outstanding word at the worst memory latency we expect
`define DATA_FIFO_DEPTH 16

`endif

// ==== common/decomp_pkg.sv ====
`include "decomp_defines.svh"

package decomp_pkg;

    // what is left of the word after the units, minus the end flag
    localparam int END_IDX_BITS = `GROUP_BITS - `UNITS_PER_GROUP * `UNIT_BITS - 1;

    // one zero run followed by one value
    typedef struct packed {
        logic [`VAL_BITS-1:0]  val;   // value byte in the upper bits
        logic [`ZERO_BITS-1:0] zero;  // zeros emitted before the value
    } compress_unit_t;

    // one memory word of the compressed stream
    typedef struct packed {
        logic                                  end_flag; // end unit carries a real value
        logic [END_IDX_BITS-1:0]               end_idx;  // index of the end unit, all ones if none
        compress_unit_t [`UNITS_PER_GROUP-1:0] units;    // unit 0 in bits 11:0
    } compress_group_t;

    // lane 0 is the first byte of the packet
    typedef logic [`PACKET_BYTES-1:0][`VAL_BITS-1:0] packet_data_t;
    typedef logic [`PACKET_BYTES-1:0]                packet_mask_t;  // one bit per lane

    typedef enum logic [1:0] {
        FETCH_IDLE,  // nothing requested since reset
        FETCH_RUN,   // requesting groups while there is room
        FETCH_DONE   // end group seen, further returns are dropped
    } fetch_state_e;

    typedef enum logic [1:0] {
        EXP_IDLE,    // no group held
        EXP_WALK,    // presenting units ahead of the last one
        EXP_LAST     // presenting the last unit of the held group
    } expand_state_e;

    typedef enum logic {
        PACK_FILL,   // placing bytes into the packet
        PACK_HOLD    // packet offered to the global buffer
    } pack_state_e;

endpackage

// ==== fetch/group_fetch.sv ====
`include "decomp_defines.svh"

module group_fetch
    import decomp_pkg::*;
(
    input  logic            layer23_gated_clk,
    input  logic            rst_n,
    input  logic            start,          // pulse, begins a new map
    input  compress_group_t mem_data,
    input  logic            mem_data_valid, // one pulse per accepted request, in order
    input  logic            mem_ack,
    input  logic            group_pop,      // expander has taken the head group
    output logic            mem_req,
    output logic            group_valid,
    output compress_group_t group
);

    localparam int PTR_BITS = $clog2(`DATA_FIFO_DEPTH);

    fetch_state_e state;

    compress_group_t data_fifo [`DATA_FIFO_DEPTH];  // returned groups waiting for the expander
    logic [PTR_BITS:0] wr_ptr;    // extra msb tells full from empty
    logic [PTR_BITS:0] rd_ptr;
    logic [PTR_BITS:0] inflight;  // accepted requests not yet answered
    logic [PTR_BITS:0] stored;    // entries currently in the fifo
    logic [PTR_BITS+1:0] used;    // slots already promised
    logic accept;
    logic store;
    logic pop;
    logic is_end;
    logic retire;

    assign stored = wr_ptr - rd_ptr;
    assign used   = {1'b0, inflight} + {1'b0, stored};

    // every request in flight owns a slot, so a returned group always finds room
    assign mem_req = (state == FETCH_RUN) && (used < (PTR_BITS + 2)'(`DATA_FIFO_DEPTH));
    assign accept  = mem_req & mem_ack;

    // data coming back after the end group belongs to nobody
    assign store  = mem_data_valid && (state == FETCH_RUN);
    assign is_end = mem_data.end_idx != END_IDX_BITS'(`END_ALL_VALID);
    assign retire = mem_data_valid && (inflight != '0);  // stray returns do not underflow

    assign group_valid = wr_ptr != rd_ptr;
    assign group       = data_fifo[rd_ptr[PTR_BITS-1:0]];
    assign pop         = group_pop & group_valid;

    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FETCH_IDLE;
        end else if (start) begin
            state <= FETCH_RUN;
        end else if (store && is_end) begin
            state <= FETCH_DONE;  // the end group itself is still kept
        end
    end

    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            inflight <= '0;
        end else if (start) begin
            wr_ptr   <= '0;  // a new map forgets whatever was left
            rd_ptr   <= '0;
            inflight <= '0;
        end else begin
            if (store) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({accept, retire})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: inflight <= inflight;  // both or neither leave the count alone
            endcase
        end
    end

    // the pointers tell which entries hold returned groups
    always_ff @(posedge layer23_gated_clk) begin
        if (store) begin
            data_fifo[wr_ptr[PTR_BITS-1:0]] <= mem_data;
        end
    end

endmodule

// ==== pack/packet_packer.sv ====
`include "decomp_defines.svh"

module packet_packer
    import decomp_pkg::*;
(
    input  logic           layer23_gated_clk,
    input  logic           rst_n,
    input  logic           start,
    input  logic           unit_valid,
    input  compress_unit_t unit,
    input  logic           unit_has_val,
    input  logic           unit_last,
    input  logic           ifmap_buffer_req,  // level from the global buffer
    output logic           unit_take,
    output logic           decompressor_ack,
    output packet_data_t   packet_data,
    output packet_mask_t   packet_mask
);

    localparam int LANE_BITS = $clog2(`PACKET_BYTES) + 1;  // counts 0 to 8 lanes
    localparam int NEED_BITS = `ZERO_BITS + 1;             // a full zero run plus the value
    localparam logic [LANE_BITS-1:0] ALL_SLOTS = LANE_BITS'(`PACKET_BYTES);

    pack_state_e state;

    packet_data_t data_q;
    packet_mask_t mask_q;
    packet_data_t data_next;
    packet_mask_t mask_next;
    logic [LANE_BITS-1:0] slots_left;    // free lanes in the packet under construction
    logic [LANE_BITS-1:0] fill_ptr;      // first free lane
    logic [LANE_BITS-1:0] slots_next;
    logic [`ZERO_BITS-1:0] zeros_left;   // zeros still owed by a unit split over packets
    logic [`ZERO_BITS-1:0] zeros;        // zeros to place for the current unit
    logic [NEED_BITS-1:0] need;          // bytes the current unit still has to place
    logic [NEED_BITS-1:0] placed;        // bytes placed this cycle
    logic mid_unit;
    logic fits;
    logic place;
    logic xfer;

    assign fill_ptr = ALL_SLOTS - slots_left;
    assign zeros    = mid_unit ? zeros_left : unit.zero;
    assign need     = NEED_BITS'(zeros) + NEED_BITS'(unit_has_val);
    assign fits     = need <= NEED_BITS'(slots_left);

    assign place      = (state == PACK_FILL) && unit_valid;
    assign unit_take  = place && fits;  // a unit that does not fit stays upstream
    assign placed     = fits ? need : NEED_BITS'(slots_left);
    assign slots_next = slots_left - LANE_BITS'(placed);

    assign xfer             = (state == PACK_HOLD) && ifmap_buffer_req;
    assign decompressor_ack = state == PACK_HOLD;
    assign packet_data      = data_q;
    assign packet_mask      = mask_q;

    // zeros go first, the value lands right after them
    // a unit that does not fit only ever places zeros, its value lane is past the packet
    always_comb begin
        data_next = data_q;
        mask_next = mask_q;
        for (int i = 0; i < `PACKET_BYTES; i++) begin
            if ((i >= fill_ptr) && (i < fill_ptr + placed)) begin
                mask_next[i] = 1'b1;
                data_next[i] = (unit_has_val && (i == fill_ptr + zeros)) ? unit.val : '0;
            end
        end
    end

    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= PACK_FILL;
            slots_left <= ALL_SLOTS;
            mask_q     <= '0;
            mid_unit   <= 1'b0;
            zeros_left <= '0;
        end else if (start) begin
            state      <= PACK_FILL;
            slots_left <= ALL_SLOTS;
            mask_q     <= '0;
            mid_unit   <= 1'b0;
            zeros_left <= '0;
        end else if (xfer) begin
            state      <= PACK_FILL;  // packet gone, begin an empty one
            slots_left <= ALL_SLOTS;
            mask_q     <= '0;
        end else if (place) begin
            mask_q     <= mask_next;
            slots_left <= slots_next;
            mid_unit   <= !fits;
            if (!fits) begin
                zeros_left <= zeros - `ZERO_BITS'(placed);  // carried into the next packet
            end
            // full packet, or the tail of the map in a partly filled one
            if ((slots_next == '0) || (fits && unit_last && (slots_next != ALL_SLOTS))) begin
                state <= PACK_HOLD;
            end
        end
    end

    // lanes outside the mask read as zero
    always_ff @(posedge layer23_gated_clk) begin
        if (start || xfer) begin
            data_q <= '0;
        end else if (place) begin
            data_q <= data_next;
        end
    end

endmodule

// ==== src/decompressor.sv ====
module decompressor
    import decomp_pkg::*;
(
    input  logic            layer23_gated_clk,  // already gated outside for layers 2 and 3
    input  logic            rst_n,
    input  logic            start,
    input  compress_group_t mem_data,
    input  logic            mem_data_valid,
    input  logic            mem_ack,
    input  logic            ifmap_buffer_req,
    output logic            mem_req,
    output logic            decompressor_ack,   // packet on packet_data is valid
    output packet_data_t    packet_data,
    output packet_mask_t    packet_mask
);

    // fetch to expander
    logic            group_valid;
    logic            group_pop;
    compress_group_t group;

    // expander to packer
    logic           unit_valid;
    logic           unit_take;
    compress_unit_t unit;
    logic           unit_has_val;
    logic           unit_last;

    // memory requests and the group fifo
    group_fetch u_fetch (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .mem_data          (mem_data),
        .mem_data_valid    (mem_data_valid),
        .mem_ack           (mem_ack),
        .group_pop         (group_pop),
        .mem_req           (mem_req),
        .group_valid       (group_valid),
        .group             (group)
    );

    // one compress unit per cycle out of the head group
    unit_expander u_expand (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .group_valid       (group_valid),
        .group             (group),
        .unit_take         (unit_take),
        .group_pop         (group_pop),
        .unit_valid        (unit_valid),
        .unit              (unit),
        .unit_has_val      (unit_has_val),
        .unit_last         (unit_last)
    );

    // zero expansion and 8-byte packets for the global buffer
    packet_packer u_pack (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .unit_valid        (unit_valid),
        .unit              (unit),
        .unit_has_val      (unit_has_val),
        .unit_last         (unit_last),
        .ifmap_buffer_req  (ifmap_buffer_req),
        .unit_take         (unit_take),
        .decompressor_ack  (decompressor_ack),
        .packet_data       (packet_data),
        .packet_mask       (packet_mask)
    );

endmodule

// ==== src/unit_expander.sv ====
`include "decomp_defines.svh"

module unit_expander
    import decomp_pkg::*;
(
    input  logic            layer23_gated_clk,
    input  logic            rst_n,
    input  logic            start,
    input  logic            group_valid,
    input  compress_group_t group,         // head of the data fifo
    input  logic            unit_take,     // packer consumes the unit this cycle
    output logic            group_pop,
    output logic            unit_valid,
    output compress_unit_t  unit,
    output logic            unit_has_val,  // value byte of this unit is real
    output logic            unit_last      // final unit of the whole map
);

    localparam int IDX_BITS = $clog2(`UNITS_PER_GROUP);
    localparam logic [IDX_BITS-1:0] LAST_FULL = IDX_BITS'(`UNITS_PER_GROUP - 1);

    expand_state_e state;

    compress_group_t cur_group;   // group being walked
    logic [IDX_BITS-1:0] unit_idx;
    logic [IDX_BITS-1:0] cur_last;  // last unit to present from cur_group
    logic [IDX_BITS-1:0] new_last;  // same for the group at the fifo head
    logic cur_is_end;
    logic load;

    // effective last unit, the end index or the top unit of a full group
    function automatic logic [IDX_BITS-1:0] last_unit(input compress_group_t g);
        if (g.end_idx == END_IDX_BITS'(`END_ALL_VALID)) begin
            return LAST_FULL;
        end
        return IDX_BITS'(g.end_idx);
    endfunction

    assign cur_is_end = cur_group.end_idx != END_IDX_BITS'(`END_ALL_VALID);
    assign cur_last   = last_unit(cur_group);
    assign new_last   = last_unit(group);

    // take a group when idle, or straight after the last unit so the stream has no gap
    assign load = !start && group_valid &&
                  ((state == EXP_IDLE) ||
                   ((state == EXP_LAST) && unit_take && !cur_is_end));
    assign group_pop = load;

    assign unit_valid = state != EXP_IDLE;
    assign unit       = cur_group.units[unit_idx];

    // in EXP_LAST the index equals the end index when the group is an end group
    assign unit_last    = (state == EXP_LAST) && cur_is_end;
    assign unit_has_val = !unit_last || cur_group.end_flag;  // a flag of 0 drops the end value

    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= EXP_IDLE;
            unit_idx <= '0;
        end else if (start) begin
            state    <= EXP_IDLE;
            unit_idx <= '0;
        end else if (load) begin
            unit_idx <= '0;
            state    <= (new_last == '0) ? EXP_LAST : EXP_WALK;  // end at unit 0 skips the walk
        end else if (unit_take) begin
            case (state)
                EXP_WALK: begin
                    unit_idx <= unit_idx + 1'b1;
                    if (unit_idx + 1'b1 == cur_last) begin
                        state <= EXP_LAST;
                    end
                end
                EXP_LAST: begin
                    state <= EXP_IDLE;  // either the map ended or the fifo ran dry
                end
                default: begin
                    state <= EXP_IDLE;
                end
            endcase
        end
    end

    // the head group is copied in when it is popped
    always_ff @(posedge layer23_gated_clk) begin
        if (load) begin
            cur_group <= group;
        end
    end

endmodule

// ==== tb/clk_gen.sv ====
module clk_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic layer23_gated_clk,
    output logic rst_n
);

    initial begin
        layer23_gated_clk = 1'b0;
        forever #(PERIOD / 2) layer23_gated_clk = ~layer23_gated_clk;
    end

    // reset leaves on a rising edge, like any other input of the DUT
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge layer23_gated_clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== tb/decompressor_chk.sv ====
module decompressor_chk
    import decomp_pkg::*;
(
    input logic         layer23_gated_clk,
    input logic         rst_n,
    input logic         mem_req,
    input logic         decompressor_ack,
    input logic         ifmap_buffer_req,
    input packet_data_t packet_data,
    input packet_mask_t packet_mask
);

    int fail_count = 0;      // read by the testbench at the end of the run
    packet_mask_t mask_inc;  // a mask of the form 2^n - 1 turns into a single bit here

    assign mask_inc = packet_mask + 1'b1;

    // an offered packet stays put until the global buffer takes it
    a_hold: assert property (@(posedge layer23_gated_clk) disable iff (!rst_n)
        (decompressor_ack && !ifmap_buffer_req) |=>
            (decompressor_ack && $stable(packet_data) && $stable(packet_mask)))
        else begin
            $error("packet changed while the global buffer held it off");
            fail_count++;
        end

    a_mask: assert property (@(posedge layer23_gated_clk) disable iff (!rst_n)
        decompressor_ack |-> ((packet_mask != '0) && ((packet_mask & mask_inc) == '0)))
        else begin
            $error("packet_mask %b is not filled from lane 0", packet_mask);
            fail_count++;
        end

    // nothing may be requested before a start
    a_idle: assert property (@(posedge layer23_gated_clk) $rose(rst_n) |-> !mem_req)
        else begin
            $error("mem_req high right after reset");
            fail_count++;
        end

endmodule

// ==== tb/tb_decompressor.sv ====
`include "decomp_defines.svh"

module tb_decompressor
    import decomp_pkg::*;
();

    localparam int TEST_GROUPS     = 98;  // upper bound, each random stream counts as 8
    localparam int TEST_RUNS       = 16;
    localparam int WATCHDOG_CYCLES = TEST_GROUPS * 40 + TEST_RUNS * 200;
    localparam int DRAIN_CYCLES    = 24;  // quiet window after the last packet

    logic            layer23_gated_clk;
    logic            rst_n;
    logic            start            = 1'b0;
    compress_group_t mem_data         = '0;
    logic            mem_data_valid   = 1'b0;
    logic            mem_ack          = 1'b0;
    logic            ifmap_buffer_req = 1'b1;
    logic            mem_req;
    logic            decompressor_ack;
    packet_data_t    packet_data;
    packet_mask_t    packet_mask;

    integer seed = 32'h4865;
    compress_group_t stream_q[$];    // groups of the running stream in request order
    int              ret_time_q[$];  // cycle in which each accepted request is answered
    packet_data_t    got_data_q[$];
    packet_mask_t    got_mask_q[$];
    packet_data_t    exp_data_q[$];
    packet_mask_t    exp_mask_q[$];
    int  req_count   = 0;     // answers given since the last start
    int  cycle       = 0;
    int  due;
    int  bp_span     = 0;
    bit  bp_on       = 1'b0;  // global buffer throttles when set
    bit  extra_offer = 1'b0;  // memory pushes unasked groups when set
    int  errors      = 0;
    int  tests_run   = 0;
    int  tests_failed = 0;

    clk_gen u_clk (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n)
    );

    decompressor u_dut (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .mem_data          (mem_data),
        .mem_data_valid    (mem_data_valid),
        .mem_ack           (mem_ack),
        .ifmap_buffer_req  (ifmap_buffer_req),
        .mem_req           (mem_req),
        .decompressor_ack  (decompressor_ack),
        .packet_data       (packet_data),
        .packet_mask       (packet_mask)
    );

    bind decompressor decompressor_chk u_chk (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .mem_req           (mem_req),
        .decompressor_ack  (decompressor_ack),
        .ifmap_buffer_req  (ifmap_buffer_req),
        .packet_data       (packet_data),
        .packet_mask       (packet_mask)
    );

    function automatic compress_group_t random_group(input int end_idx, input bit flag,
                                                     input int zero_lo, input int zero_hi);
        compress_group_t g;
        for (int u = 0; u < `UNITS_PER_GROUP; u++) begin
            g.units[u].zero = `ZERO_BITS'(zero_lo +
                int'($unsigned($random(seed)) % (zero_hi - zero_lo + 1)));
            g.units[u].val  = `VAL_BITS'($random(seed));  // units past the end hold junk too
        end
        g.end_idx  = END_IDX_BITS'(end_idx);
        g.end_flag = flag;
        return g;
    endfunction

    function automatic void add_full_groups(input int n, input int zero_lo, input int zero_hi);
        repeat (n) stream_q.push_back(random_group(`END_ALL_VALID, 1'b1, zero_lo, zero_hi));
    endfunction

    // byte stream of the map as the compress format defines it, cut into packets
    function automatic void model_packets();
        logic [`VAL_BITS-1:0] bytes[$];
        packet_data_t data;
        packet_mask_t mask;
        int e;
        exp_data_q.delete();
        exp_mask_q.delete();
        foreach (stream_q[g]) begin
            e = stream_q[g].end_idx;
            for (int u = 0; u < `UNITS_PER_GROUP; u++) begin
                if (e == `END_ALL_VALID || u <= e) begin
                    repeat (stream_q[g].units[u].zero) bytes.push_back('0);
                    if (e == `END_ALL_VALID || u < e || stream_q[g].end_flag)
                        bytes.push_back(stream_q[g].units[u].val);
                end
            end
            if (e != `END_ALL_VALID) break;  // end group closes the map
        end
        for (int i = 0; i < bytes.size(); i += `PACKET_BYTES) begin
            data = '0;
            mask = '0;
            for (int l = 0; l < `PACKET_BYTES && i + l < bytes.size(); l++) begin
                data[l] = bytes[i + l];
                mask[l] = 1'b1;
            end
            exp_data_q.push_back(data);
            exp_mask_q.push_back(mask);
        end
    endfunction

    // only lanes inside the mask carry map bytes
    function automatic packet_data_t masked(input packet_data_t d, input packet_mask_t m);
        packet_data_t r;
        r = '0;
        for (int l = 0; l < `PACKET_BYTES; l++) begin
            if (m[l]) r[l] = d[l];
        end
        return r;
    endfunction

    task automatic check_data(input string name, input packet_data_t exp, input packet_data_t act);
        if (exp !== act) begin
            $display("** Error [%s] packet_data expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_mask(input string name, input packet_mask_t exp, input packet_mask_t act);
        if (exp !== act) begin
            $display("** Error [%s] packet_mask expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error [%s] expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    // starts the map held in stream_q, collects its packets and compares them
    task automatic run_stream(input string name, input bit backpressure, input bit offer_extra);
        int errs_before;
        bit req_seen;
        string tag;
        errs_before = errors;
        req_seen = 1'b0;
        model_packets();
        got_data_q.delete();
        got_mask_q.delete();
        req_count = 0;
        bp_on = backpressure;
        @(posedge layer23_gated_clk);
        start <= 1'b1;
        @(posedge layer23_gated_clk);
        start <= 1'b0;
        while (got_data_q.size() < exp_data_q.size()) @(negedge layer23_gated_clk);
        bp_on = 1'b0;                      // any surplus packet would now be taken and seen
        extra_offer = offer_extra;
        while (ret_time_q.size() > 0) @(negedge layer23_gated_clk);
        repeat (DRAIN_CYCLES) begin
            @(negedge layer23_gated_clk);
            req_seen |= mem_req;           // fetch must be done once the end group is in
        end
        extra_offer = 1'b0;
        if (req_seen) begin
            $display("[%s] mem_req went high again after the end group", name);
            errors++;
        end
        if (got_data_q.size() != exp_data_q.size()) begin
            $display("[%s] received %0d packets where %0d were due", name,
                     got_data_q.size(), exp_data_q.size());
            errors++;
        end
        for (int i = 0; i < exp_data_q.size() && i < got_data_q.size(); i++) begin
            tag = $sformatf("%s packet %0d", name, i);
            check_data(tag, exp_data_q[i], masked(got_data_q[i], got_mask_q[i]));
            check_mask(tag, exp_mask_q[i], got_mask_q[i]);
        end
        tests_run++;
        if (errors == errs_before) begin
            $display("%-14s ok, %0d packets", name, got_data_q.size());
        end else begin
            tests_failed++;
            $display("%-14s failed with %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic reset_and_single();
        check_bit("reset mem_req", 1'b0, mem_req);
        check_bit("reset decompressor_ack", 1'b0, decompressor_ack);
        stream_q.delete();
        stream_q.push_back(random_group(2, 1'b1, 0, 3));
        run_stream("single_group", 1'b0, 1'b0);
    endtask

    task automatic multi_group_stream();
        stream_q.delete();
        add_full_groups(3, 15, 15);  // every run spills over a packet edge
        stream_q.push_back(random_group(3, 1'b0, 0, 15));
        run_stream("multi_group", 1'b0, 1'b0);
    endtask

    task automatic backpressure_stream();
        stream_q.delete();
        add_full_groups(5, 0, 15);
        stream_q.push_back(random_group(1 + int'($unsigned($random(seed)) % 4), 1'b1, 0, 15));
        run_stream("backpressure", 1'b1, 1'b0);
    endtask

    task automatic stop_on_end();
        stream_q.delete();
        add_full_groups(1, 0, 7);
        stream_q.push_back(random_group(4, 1'b1, 0, 7));
        run_stream("stop_on_end", 1'b0, 1'b1);
    endtask

    task automatic random_streams();
        int n;
        int e;
        bit f;
        bit bp;
        for (int k = 0; k < 10; k++) begin
            n  = 1 + int'($unsigned($random(seed)) % 8);
            e  = int'($unsigned($random(seed)) % `UNITS_PER_GROUP);
            f  = (e == 0) ? 1'b1 : 1'($random(seed));  // end group always gives a byte
            bp = 1'($random(seed));
            stream_q.delete();
            add_full_groups(n - 1, 0, 15);
            stream_q.push_back(random_group(e, f, 0, 15));
            run_stream($sformatf("random_%0d", k), bp, 1'b0);
        end
    endtask

    task automatic restart_stream();
        stream_q.delete();
        add_full_groups(1, 0, 15);
        stream_q.push_back(random_group(3, 1'b1, 0, 15));
        run_stream("restart_a", 1'b1, 1'b0);
        stream_q.delete();
        add_full_groups(2, 8, 15);
        stream_q.push_back(random_group(0, 1'b1, 0, 15));
        run_stream("restart_b", 1'b0, 1'b0);
    endtask

    // memory and global buffer, all random draws of the clock edge happen here
    always @(posedge layer23_gated_clk) begin
        cycle++;
        if (rst_n && mem_req && mem_ack) begin
            due = cycle + 1 + int'($unsigned($random(seed)) % 16);
            if (ret_time_q.size() > 0 && due <= ret_time_q[$]) begin
                due = ret_time_q[$] + 1;  // answers stay in order, one per cycle
            end
            ret_time_q.push_back(due);
        end
        mem_ack <= 1'($random(seed));
        if (ret_time_q.size() > 0 && ret_time_q[0] <= cycle) begin
            void'(ret_time_q.pop_front());
            mem_data_valid <= 1'b1;
            // requests past the end group are answered with groups no one should see
            mem_data <= (req_count < stream_q.size()) ? stream_q[req_count] :
                        random_group(`END_ALL_VALID, 1'b1, 0, 15);
            req_count++;
        end else if (extra_offer && 1'($random(seed))) begin
            mem_data_valid <= 1'b1;
            mem_data       <= random_group(`END_ALL_VALID, 1'b1, 0, 15);
        end else begin
            mem_data_valid <= 1'b0;
        end
        if (rst_n && decompressor_ack && ifmap_buffer_req) begin
            got_data_q.push_back(packet_data);
            got_mask_q.push_back(packet_mask);
        end
        if (!bp_on) begin
            ifmap_buffer_req <= 1'b1;
        end else if (bp_span > 0) begin
            bp_span--;                    // keep the level for the rest of the span
        end else begin
            ifmap_buffer_req <= !ifmap_buffer_req;
            bp_span = int'($unsigned($random(seed)) % 6);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge layer23_gated_clk);
        $display("watchdog expired after %0d cycles with the stream unfinished", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        wait (rst_n === 1'b1);
        @(negedge layer23_gated_clk);
        reset_and_single();
        multi_group_stream();
        backpressure_stream();
        stop_on_end();
        random_streams();
        restart_stream();
        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, u_dut.u_chk.fail_count);
        if (errors == 0 && tests_failed == 0 && u_dut.u_chk.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+common
common/decomp_pkg.sv
fetch/group_fetch.sv
src/unit_expander.sv
pack/packet_packer.sv
src/decompressor.sv
tb/clk_gen.sv
tb/decompressor_chk.sv
tb/tb_decompressor.sv
